//--- flist.f
rtl/f2c_pkg.sv
rtl/ring_if.sv
rtl/pkt_framer.sv
rtl/sync_fifo.sv
rtl/host_ring_tracker.sv
rtl/dma_burst_writer.sv
rtl/fpga2cpu_dma.sv
tests/tb_clock_gen.sv
tests/tb_fpga2cpu_dma.sv

//--- rtl/dma_burst_writer.sv
`timescale 1ns/1ps

module dma_burst_writer (
    input  logic                            clk,
    input  logic                            rst,
    input  f2c_pkg::flit_t                  flit_in,
    input  logic                            flit_valid,
    output logic                            flit_pop,
    input  f2c_pkg::pkt_dsc_t               dsc_in,
    input  logic                            dsc_valid,
    output logic                            dsc_pop,
    ring_if.writer                          ring,
    input  logic [63:0]                     pkt_ring_base,
    input  logic [63:0]                     dsc_ring_base,
    input  logic                            bas_waitrequest,
    output logic [63:0]                     bas_address,
    output logic                            bas_write,
    output logic [f2c_pkg::FLIT_BITS-1:0]   bas_writedata,
    output logic [f2c_pkg::BURST_WIDTH-1:0] bas_burstcount
);
    import f2c_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        BURST_START,
        BURST_BODY,
        DSC_WRITE
    } state_t;

    state_t                 state;
    logic [SIZE_WIDTH-1:0]  remaining;
    logic [BURST_WIDTH-1:0] beats_left;
    logic [RING_AWIDTH:0]   room_to_end;
    logic [RING_AWIDTH:0]   len_w;
    logic [BURST_WIDTH-1:0] burst_len;
    logic                   in_burst;
    logic                   accept;
    logic                   pkt_fits;
    host_dsc_t              host_dsc;

    assign in_burst = (state == BURST_START) || (state == BURST_BODY);
    assign accept = bas_write && !bas_waitrequest;

    // a burst must stop at the last slot of the packet ring
    assign room_to_end = (RING_AWIDTH + 1)'(PKT_RING_SLOTS) - {1'b0, ring.pkt_tail};

    always_comb begin
        len_w = (RING_AWIDTH + 1)'(remaining);
        if (len_w > (RING_AWIDTH + 1)'(MAX_BURST)) begin
            len_w = (RING_AWIDTH + 1)'(MAX_BURST);
        end
        if (len_w > room_to_end) begin
            len_w = room_to_end;
        end
        burst_len = len_w[BURST_WIDTH-1:0];
    end

    // the whole packet is reserved up front, later bursts never recheck
    assign pkt_fits = RING_AWIDTH'(dsc_in.size) <= ring.pkt_free;

    always_comb begin
        host_dsc = '0;
        host_dsc.signal = 1'b1;
        host_dsc.tail = 32'(ring.pkt_tail);
        host_dsc.queue_id = dsc_in.queue_id;
    end

    // bus is driven from the fifo heads, which hold until popped
    always_comb begin
        bas_write = 1'b0;
        bas_address = pkt_ring_base + 64'(ring.pkt_tail) * 64'(FLIT_BYTES);
        bas_writedata = flit_in.data;
        bas_burstcount = beats_left;
        case (state)
            BURST_START: begin
                bas_write = flit_valid;
                bas_burstcount = burst_len;
            end
            BURST_BODY: begin
                bas_write = flit_valid;
            end
            DSC_WRITE: begin
                bas_write = 1'b1;
                bas_address = dsc_ring_base + 64'(ring.dsc_tail) * 64'(FLIT_BYTES);
                bas_writedata = host_dsc;
                bas_burstcount = BURST_WIDTH'(1);
            end
            default: begin
                bas_write = 1'b0;
            end
        endcase
    end

    assign flit_pop = in_burst && accept;
    assign dsc_pop = (state == DSC_WRITE) && accept;
    assign ring.pkt_advance = flit_pop;
    assign ring.dsc_advance = dsc_pop;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            remaining <= '0;
            beats_left <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (dsc_valid && pkt_fits && ring.dsc_free != '0) begin
                        remaining <= dsc_in.size;
                        state <= BURST_START;
                    end
                end
                BURST_START: begin
                    if (accept) begin
                        remaining <= remaining - 1'b1;
                        beats_left <= burst_len - 1'b1;
                        // single-beat bursts stay here for the next one
                        if (burst_len != BURST_WIDTH'(1)) begin
                            state <= BURST_BODY;
                        end else if (remaining == SIZE_WIDTH'(1)) begin
                            state <= DSC_WRITE;
                        end
                    end
                end
                BURST_BODY: begin
                    if (accept) begin
                        remaining <= remaining - 1'b1;
                        beats_left <= beats_left - 1'b1;
                        if (beats_left == BURST_WIDTH'(1)) begin
                            if (remaining == SIZE_WIDTH'(1)) begin
                                state <= DSC_WRITE;
                            end else begin
                                state <= BURST_START;
                            end
                        end
                    end
                end
                DSC_WRITE: begin
                    if (accept) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

//--- rtl/f2c_pkg.sv
package f2c_pkg;

    // flit and host slot geometry
    localparam int FLIT_BITS = 512;
    localparam int FLIT_BYTES = 64;

    // burst limits on the host bus
    localparam int MAX_BURST = 8;
    localparam int BURST_WIDTH = 4;

    // host ring sizes, fixed at build time
    localparam int PKT_RING_SLOTS = 64;
    localparam int DSC_RING_SLOTS = 16;
    localparam int RING_AWIDTH = 6;

    localparam int QUEUE_ID_WIDTH = 8;
    localparam int MAX_PKT_FLITS = 16;
    localparam int SIZE_WIDTH = 5;

    // must hold a whole packet so the descriptor only appears after all its flits
    localparam int FIFO_DEPTH = 32;

    typedef struct packed {
        logic [FLIT_BITS-1:0] data;
        logic                 sop;
        logic                 eop;
    } flit_t;

    // internal descriptor, size counted in flits
    typedef struct packed {
        logic [QUEUE_ID_WIDTH-1:0] queue_id;
        logic [SIZE_WIDTH-1:0]     size;
    } pkt_dsc_t;

    // one host descriptor slot, signal bit in bit 0
    typedef struct packed {
        logic [FLIT_BITS-QUEUE_ID_WIDTH-34:0] pad;
        logic [QUEUE_ID_WIDTH-1:0]            queue_id;
        logic [31:0]                          tail;
        logic                                 signal;
    } host_dsc_t;

endpackage

//--- rtl/fpga2cpu_dma.sv
`timescale 1ns/1ps

module fpga2cpu_dma (
    input  logic                               clk,
    input  logic                               rst,

    // packet flits from the fabric
    input  f2c_pkg::flit_t                     in_flit,
    input  logic [f2c_pkg::QUEUE_ID_WIDTH-1:0] in_queue_id,
    input  logic                               in_valid,
    output logic                               in_ready,

    // host ring state
    input  logic [f2c_pkg::RING_AWIDTH-1:0]    pkt_ring_head,
    input  logic [f2c_pkg::RING_AWIDTH-1:0]    dsc_ring_head,
    input  logic [63:0]                        pkt_ring_base,
    input  logic [63:0]                        dsc_ring_base,

    // host burst write bus
    input  logic                               bas_waitrequest,
    output logic [63:0]                        bas_address,
    output logic                               bas_write,
    output logic [f2c_pkg::FLIT_BITS-1:0]      bas_writedata,
    output logic [f2c_pkg::BURST_WIDTH-1:0]    bas_burstcount,

    // tail updates toward the host
    output logic [f2c_pkg::RING_AWIDTH-1:0]    pkt_ring_tail,
    output logic [f2c_pkg::RING_AWIDTH-1:0]    dsc_ring_tail,
    output logic                               tail_valid
);
    import f2c_pkg::*;

    flit_t    frm_flit;
    logic     frm_flit_push;
    logic     pkt_fifo_room;
    pkt_dsc_t frm_dsc;
    logic     frm_dsc_push;
    logic     dsc_fifo_room;

    flit_t    head_flit;
    logic     head_flit_valid;
    logic     flit_pop;
    pkt_dsc_t head_dsc;
    logic     head_dsc_valid;
    logic     dsc_pop;

    ring_if ring ();

    pkt_framer pkt_framer_inst (
        .clk         (clk),
        .rst         (rst),
        .in_flit     (in_flit),
        .in_queue_id (in_queue_id),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .flit_out    (frm_flit),
        .flit_push   (frm_flit_push),
        .flit_room   (pkt_fifo_room),
        .dsc_out     (frm_dsc),
        .dsc_push    (frm_dsc_push),
        .dsc_room    (dsc_fifo_room)
    );

    sync_fifo #(
        .payload_t (flit_t),
        .DEPTH     (FIFO_DEPTH)
    ) pkt_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_data   (frm_flit),
        .in_valid  (frm_flit_push),
        .in_ready  (pkt_fifo_room),
        .out_data  (head_flit),
        .out_valid (head_flit_valid),
        .out_ready (flit_pop)
    );

    sync_fifo #(
        .payload_t (pkt_dsc_t),
        .DEPTH     (FIFO_DEPTH)
    ) dsc_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_data   (frm_dsc),
        .in_valid  (frm_dsc_push),
        .in_ready  (dsc_fifo_room),
        .out_data  (head_dsc),
        .out_valid (head_dsc_valid),
        .out_ready (dsc_pop)
    );

    host_ring_tracker host_ring_tracker_inst (
        .clk           (clk),
        .rst           (rst),
        .pkt_ring_head (pkt_ring_head),
        .dsc_ring_head (dsc_ring_head),
        .ring          (ring.tracker),
        .pkt_ring_tail (pkt_ring_tail),
        .dsc_ring_tail (dsc_ring_tail),
        .tail_valid    (tail_valid)
    );

    dma_burst_writer dma_burst_writer_inst (
        .clk             (clk),
        .rst             (rst),
        .flit_in         (head_flit),
        .flit_valid      (head_flit_valid),
        .flit_pop        (flit_pop),
        .dsc_in          (head_dsc),
        .dsc_valid       (head_dsc_valid),
        .dsc_pop         (dsc_pop),
        .ring            (ring.writer),
        .pkt_ring_base   (pkt_ring_base),
        .dsc_ring_base   (dsc_ring_base),
        .bas_waitrequest (bas_waitrequest),
        .bas_address     (bas_address),
        .bas_write       (bas_write),
        .bas_writedata   (bas_writedata),
        .bas_burstcount  (bas_burstcount)
    );

endmodule

//--- rtl/host_ring_tracker.sv
`timescale 1ns/1ps

module host_ring_tracker (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [f2c_pkg::RING_AWIDTH-1:0] pkt_ring_head,
    input  logic [f2c_pkg::RING_AWIDTH-1:0] dsc_ring_head,
    ring_if.tracker                         ring,
    output logic [f2c_pkg::RING_AWIDTH-1:0] pkt_ring_tail,
    output logic [f2c_pkg::RING_AWIDTH-1:0] dsc_ring_tail,
    output logic                            tail_valid
);
    import f2c_pkg::*;

    function automatic logic [RING_AWIDTH-1:0] next_ptr(
        logic [RING_AWIDTH-1:0] ptr,
        int                     slots
    );
        if (ptr == RING_AWIDTH'(slots - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // free slots, keeping one empty so full and empty differ
    function automatic logic [RING_AWIDTH-1:0] free_slots(
        logic [RING_AWIDTH-1:0] tail,
        logic [RING_AWIDTH-1:0] head,
        int                     slots
    );
        logic [RING_AWIDTH-1:0] used;
        if (tail >= head) begin
            used = tail - head;
        end else begin
            used = tail + RING_AWIDTH'(slots) - head;
        end
        return RING_AWIDTH'(slots - 1) - used;
    endfunction

    assign ring.pkt_free = free_slots(ring.pkt_tail, pkt_ring_head, PKT_RING_SLOTS);
    assign ring.dsc_free = free_slots(ring.dsc_tail, dsc_ring_head, DSC_RING_SLOTS);

    always_ff @(posedge clk) begin
        if (rst) begin
            ring.pkt_tail <= '0;
            ring.dsc_tail <= '0;
            tail_valid <= 1'b0;
        end else begin
            if (ring.pkt_advance) begin
                ring.pkt_tail <= next_ptr(ring.pkt_tail, PKT_RING_SLOTS);
            end
            if (ring.dsc_advance) begin
                ring.dsc_tail <= next_ptr(ring.dsc_tail, DSC_RING_SLOTS);
            end
            // tails have already moved when this pulse is seen
            tail_valid <= ring.dsc_advance;
        end
    end

    assign pkt_ring_tail = ring.pkt_tail;
    assign dsc_ring_tail = ring.dsc_tail;

endmodule

//--- rtl/pkt_framer.sv
`timescale 1ns/1ps

module pkt_framer (
    input  logic                               clk,
    input  logic                               rst,
    input  f2c_pkg::flit_t                     in_flit,
    input  logic [f2c_pkg::QUEUE_ID_WIDTH-1:0] in_queue_id,
    input  logic                               in_valid,
    output logic                               in_ready,
    output f2c_pkg::flit_t                     flit_out,
    output logic                               flit_push,
    input  logic                               flit_room,
    output f2c_pkg::pkt_dsc_t                  dsc_out,
    output logic                               dsc_push,
    input  logic                               dsc_room
);
    import f2c_pkg::*;

    // flits accepted so far in the open packet
    logic [SIZE_WIDTH-1:0]     flit_cnt;
    logic [QUEUE_ID_WIDTH-1:0] queue_id_q;
    logic                      accept;

    // end flit also needs a descriptor slot
    assign in_ready = flit_room && (!in_flit.eop || dsc_room);
    assign accept = in_valid && in_ready;

    assign flit_out = in_flit;
    assign flit_push = accept;
    assign dsc_push = accept && in_flit.eop;

    // a start flit counts as one, so single-flit packets need no state
    always_comb begin
        dsc_out.queue_id = in_flit.sop ? in_queue_id : queue_id_q;
        dsc_out.size = in_flit.sop ? SIZE_WIDTH'(1) : flit_cnt + 1'b1;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            flit_cnt <= '0;
        end else if (accept) begin
            if (in_flit.eop) begin
                flit_cnt <= '0;
            end else if (in_flit.sop) begin
                flit_cnt <= SIZE_WIDTH'(1);
            end else begin
                flit_cnt <= flit_cnt + 1'b1;
            end
        end
    end

    // queue id is only valid on the start flit
    always_ff @(posedge clk) begin
        if (accept && in_flit.sop) begin
            queue_id_q <= in_queue_id;
        end
    end

endmodule

//--- rtl/ring_if.sv
`timescale 1ns/1ps

interface ring_if;
    import f2c_pkg::*;

    // ring state owned by the tracker
    logic [RING_AWIDTH-1:0] pkt_tail;
    logic [RING_AWIDTH-1:0] dsc_tail;
    logic [RING_AWIDTH-1:0] pkt_free;
    logic [RING_AWIDTH-1:0] dsc_free;

    // one slot per pulse, driven by the writer
    logic                   pkt_advance;
    logic                   dsc_advance;

    modport tracker (
        output pkt_tail, dsc_tail, pkt_free, dsc_free,
        input  pkt_advance, dsc_advance
    );

    modport writer (
        input  pkt_tail, dsc_tail, pkt_free, dsc_free,
        output pkt_advance, dsc_advance
    );

endinterface

//--- rtl/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH = f2c_pkg::FIFO_DEPTH
) (
    input  logic     clk,
    input  logic     rst,
    input  payload_t in_data,
    input  logic     in_valid,
    output logic     in_ready,
    output payload_t out_data,
    output logic     out_valid,
    input  logic     out_ready
);

    payload_t                     mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]     wr_ptr;
    logic [$clog2(DEPTH)-1:0]     rd_ptr;
    logic [$clog2(DEPTH+1)-1:0]   count;
    logic                         push;
    logic                         pop;

    assign in_ready = count != ($clog2(DEPTH+1))'(DEPTH);
    assign out_valid = count != '0;

    // head is read straight from the array
    assign out_data = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                // wrap explicitly, depth need not be a power of two
                if (wr_ptr == ($clog2(DEPTH))'(DEPTH - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (pop) begin
                if (rd_ptr == ($clog2(DEPTH))'(DEPTH - 1)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- run.sh
#!/usr/bin/env bash
# build the testbench with verilator and run it, the exit status carries the result
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module tb_fpga2cpu_dma -f flist.f -o sim_tb &&
./obj_dir/sim_tb ||
exit 1

//--- tests/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 20,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // release lands just after an edge, like the other stimulus
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

//--- tests/tb_fpga2cpu_dma.sv
`timescale 1ns/1ps

module tb_fpga2cpu_dma;
    import f2c_pkg::*;

    localparam int N_RANDOM = 40;
    // directed packets of 1, 13 and three of 16, then 5 held back by the packet ring,
    // then fifteen of 1 and one more held back by the descriptor ring
    localparam int N_PACKETS = N_RANDOM + 22;
    localparam int STALL_CYCLES = 60;
    localparam logic [63:0] PKT_BASE = 64'h0000_0001_0000_0000;
    localparam logic [63:0] DSC_BASE = 64'h0000_0002_0040_0000;

    typedef struct packed {
        logic [63:0]            addr;
        logic [FLIT_BITS-1:0]   data;
        logic [BURST_WIDTH-1:0] count;
        logic                   starts;
    } beat_t;

    logic                      clk;
    logic                      rst;
    flit_t                     in_flit;
    logic [QUEUE_ID_WIDTH-1:0] in_queue_id;
    logic                      in_valid;
    logic                      in_ready;
    logic [RING_AWIDTH-1:0]    pkt_ring_head;
    logic [RING_AWIDTH-1:0]    dsc_ring_head;
    logic [63:0]               pkt_ring_base;
    logic [63:0]               dsc_ring_base;
    logic                      bas_waitrequest;
    logic [63:0]               bas_address;
    logic                      bas_write;
    logic [FLIT_BITS-1:0]      bas_writedata;
    logic [BURST_WIDTH-1:0]    bas_burstcount;
    logic [RING_AWIDTH-1:0]    pkt_ring_tail;
    logic [RING_AWIDTH-1:0]    dsc_ring_tail;
    logic                      tail_valid;

    beat_t                    exp_beats[$];
    logic [2*RING_AWIDTH-1:0] exp_tails[$];
    logic [FLIT_BITS-1:0]     pkt_data[MAX_PKT_FLITS];
    int                       ref_pkt_tail = 0;
    int                       ref_dsc_tail = 0;
    int                       packets_done = 0;
    logic [15:0]              lfsr_state;
    logic                     random_wait = 1'b0;
    logic                     follow_heads = 1'b0;

    tb_clock_gen #(.PERIOD_NS(20), .RESET_CYCLES(16)) clock_gen_inst (.clk(clk), .rst(rst));

    fpga2cpu_dma fpga2cpu_dma_inst (.*);

    // 16-bit fibonacci lfsr with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    function automatic logic [FLIT_BITS-1:0] rand_bits(int n);
        logic [FLIT_BITS-1:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v[i] = lfsr_state[0];
        end
        return v;
    endfunction

    task automatic abort_run(string what);
        $display("%s", what);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_value(string name, logic [FLIT_BITS-1:0] expected,
                               logic [FLIT_BITS-1:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("Fail at %0t ns: %s expected %0h actual %0h",
                                $time, name, expected, actual));
        end
    endtask

    // expected beats of one packet split by size, MAX_BURST and the ring end
    function automatic void predict_packet(int size, logic [QUEUE_ID_WIDTH-1:0] qid);
        beat_t                b;
        int                   left;
        int                   len;
        int                   k;
        logic [FLIT_BITS-1:0] dsc;
        left = size;
        k = 0;
        while (left > 0) begin
            len = left;
            if (len > MAX_BURST) begin
                len = MAX_BURST;
            end
            if (len > PKT_RING_SLOTS - ref_pkt_tail) begin
                len = PKT_RING_SLOTS - ref_pkt_tail;
            end
            for (int i = 0; i < len; i++) begin
                b.addr = PKT_BASE + 64'(ref_pkt_tail) * 64'(FLIT_BYTES);
                b.data = pkt_data[k];
                b.count = BURST_WIDTH'(len);
                b.starts = (i == 0);
                exp_beats.push_back(b);
                ref_pkt_tail = (ref_pkt_tail + 1) % PKT_RING_SLOTS;
                k++;
            end
            left -= len;
        end
        // host descriptor with signal bit, new packet tail and queue id
        dsc = '0;
        dsc[0] = 1'b1;
        dsc[32:1] = 32'(ref_pkt_tail);
        dsc[33 +: QUEUE_ID_WIDTH] = qid;
        b.addr = DSC_BASE + 64'(ref_dsc_tail) * 64'(FLIT_BYTES);
        b.data = dsc;
        b.count = BURST_WIDTH'(1);
        b.starts = 1'b1;
        exp_beats.push_back(b);
        ref_dsc_tail = (ref_dsc_tail + 1) % DSC_RING_SLOTS;
        exp_tails.push_back({RING_AWIDTH'(ref_pkt_tail), RING_AWIDTH'(ref_dsc_tail)});
    endfunction

    task automatic send_packet(int size, logic [QUEUE_ID_WIDTH-1:0] qid);
        logic took;
        for (int k = 0; k < size; k++) begin
            pkt_data[k] = rand_bits(FLIT_BITS);
        end
        predict_packet(size, qid);
        for (int k = 0; k < size; k++) begin
            in_flit.data = pkt_data[k];
            in_flit.sop = (k == 0);
            in_flit.eop = (k == size - 1);
            // queue id only counts on the start flit
            in_queue_id = (k == 0) ? qid : ~qid;
            in_valid = 1'b1;
            took = 1'b0;
            while (!took) begin
                @(negedge clk);
                took = in_ready;
                @(posedge clk);
                #1;
            end
        end
        in_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_beats.size() != 0 || exp_tails.size() != 0) begin
            @(posedge clk);
        end
        #1;
    endtask

    task automatic expect_bus_idle(string what);
        repeat (STALL_CYCLES) begin
            @(negedge clk);
            if (bas_write) begin
                abort_run(what);
            end
        end
        @(posedge clk);
        #1;
    endtask

    // compare process samples outputs mid cycle
    always @(negedge clk) begin
        beat_t                    b;
        logic [2*RING_AWIDTH-1:0] t;
        if (!rst && bas_write && !bas_waitrequest) begin
            if (exp_beats.size() == 0) begin
                abort_run("a write was accepted on the bus with no beat expected");
            end else begin
                b = exp_beats.pop_front();
                if (b.starts) begin
                    check_value("bas_address", FLIT_BITS'(b.addr), FLIT_BITS'(bas_address));
                    check_value("bas_burstcount", FLIT_BITS'(b.count),
                                FLIT_BITS'(bas_burstcount));
                end
                check_value("bas_writedata", b.data, bas_writedata);
            end
        end
        if (!rst && tail_valid) begin
            if (exp_tails.size() == 0) begin
                abort_run("tail_valid pulsed with no finished packet");
            end else begin
                t = exp_tails.pop_front();
                check_value("pkt_ring_tail", FLIT_BITS'(t[2*RING_AWIDTH-1:RING_AWIDTH]),
                            FLIT_BITS'(pkt_ring_tail));
                check_value("dsc_ring_tail", FLIT_BITS'(t[RING_AWIDTH-1:0]),
                            FLIT_BITS'(dsc_ring_tail));
                packets_done++;
            end
        end
    end

    // host bus back-pressure
    initial begin
        logic [15:0] wait_lfsr;
        logic        use_random;
        wait_lfsr = 16'd8464;
        bas_waitrequest = 1'b0;
        forever begin
            @(posedge clk);
            use_random = random_wait;
            #1;
            if (use_random) begin
                wait_lfsr = lfsr_next(wait_lfsr);
                bas_waitrequest = wait_lfsr[0];
            end else begin
                bas_waitrequest = 1'b0;
            end
        end
    end

    // host model frees every slot announced by a tail update
    // and catches up with the tails when its heads are released
    initial begin
        logic [RING_AWIDTH-1:0] pkt_next;
        logic [RING_AWIDTH-1:0] dsc_next;
        logic                   synced;
        pkt_ring_head = '0;
        dsc_ring_head = '0;
        synced = 1'b0;
        forever begin
            @(negedge clk);
            if (!follow_heads) begin
                synced = 1'b0;
            end else if (tail_valid || !synced) begin
                pkt_next = pkt_ring_tail;
                dsc_next = dsc_ring_tail;
                synced = 1'b1;
                @(posedge clk);
                #1;
                pkt_ring_head = pkt_next;
                dsc_ring_head = dsc_next;
            end
        end
    end

    initial begin
        repeat (N_PACKETS * MAX_PKT_FLITS * 20 + 2 * STALL_CYCLES + 1000) @(posedge clk);
        abort_run("watchdog expired, the run hung");
    end

    initial begin
        int                        size;
        logic [QUEUE_ID_WIDTH-1:0] qid;
        lfsr_state = 16'd8464;
        in_flit = '0;
        in_queue_id = '0;
        in_valid = 1'b0;
        pkt_ring_base = PKT_BASE;
        dsc_ring_base = DSC_BASE;
        @(negedge rst);

        send_packet(1, QUEUE_ID_WIDTH'(8'h5a));
        wait_drain();
        send_packet(13, QUEUE_ID_WIDTH'(8'hc3));
        wait_drain();

        // with heads held at zero the ring ends at tail 62 with one slot free
        repeat (3) send_packet(16, QUEUE_ID_WIDTH'(rand_bits(QUEUE_ID_WIDTH)));
        wait_drain();
        send_packet(5, QUEUE_ID_WIDTH'(8'h21));
        expect_bus_idle("the writer started a packet that does not fit the packet ring");
        // freeing the ring lets the held packet wrap at the ring end
        follow_heads = 1'b1;
        wait_drain();

        // heads held again while one-flit packets fill the descriptor ring
        follow_heads = 1'b0;
        repeat (DSC_RING_SLOTS - 1) send_packet(1, QUEUE_ID_WIDTH'(rand_bits(QUEUE_ID_WIDTH)));
        wait_drain();
        send_packet(1, QUEUE_ID_WIDTH'(8'h7e));
        expect_bus_idle("the writer started a packet with no free descriptor slot");
        follow_heads = 1'b1;
        wait_drain();

        random_wait = 1'b1;
        for (int p = 0; p < N_RANDOM; p++) begin
            size = int'(rand_bits(4)) + 1;
            qid = QUEUE_ID_WIDTH'(rand_bits(QUEUE_ID_WIDTH));
            send_packet(size, qid);
        end
        wait_drain();

        if (packets_done != N_PACKETS) begin
            abort_run("fewer tail updates arrived than packets were sent");
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule
